// File: filelist.f
hw/fpgaCtrlPkg.sv
hw/spiRegPort.sv
hw/regBank.sv
hw/linkStatusLeds.sv
hw/fpgaCtrlTop.sv
bench/fpgaCtrlChecker.sv
bench/fpgaCtrl_props.sv
bench/fpgaCtrlTb.sv

// File: Makefile
# Verilator build and run of the FPGA control block testbench

TOP := fpgaCtrlTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/fpgaCtrlTb.sv
// Testbench for the FPGA control block
// Drives SPI frames as the board controller, keeps a model of the registers
// The checker compares read words, setting outputs and LED patterns
`timescale 1ns/1ns
`default_nettype none

module fpgaCtrlTb;
	import fpgaCtrlPkg::*;

	localparam regData_t VERSION = 32'h0001_0203;
	localparam flags_t FLAGS = 6'h15;
	localparam int BLINK_BITS = 4;
	// About 124 frames of 48 SCLK periods, 10 clocks each, plus LED windows
	localparam int FRAMES = 140;
	localparam int TIMEOUT_NS = FRAMES * 48 * 10 * 10 + 100000;
	localparam logic [1:0] LED_STEADY = 2'd0;
	localparam logic [1:0] LED_BLINK  = 2'd1;
	localparam logic [1:0] LED_DIM    = 2'd2;

	logic CLK_IN;
	logic RESET_IN;
	logic spiSclk;
	logic spiCsN;
	logic spiMosi;
	logic spiMiso;
	logic [3:0] linkUp;
	logic [3:0] ledOut;
	regData_t linkEnable;
	regData_t periphKey;
	regData_t periphMask;
	regData_t scrambleIdle;
	gtCfg_t gtCfg;
	// Checker controls
	logic [127:0] testName;
	logic readCheck;
	logic outCheck;
	logic ledCheck;
	regData_t expRead;
	logic [7:0] ledMode;
	int checkCount;
	int errorCount;
	// Register model
	regData_t modelKey;
	regData_t modelMask;
	regData_t modelScramble;
	regData_t modelLinkEn;
	ledOvr_t modelLedOvr;
	gtCfg_t modelGt;
	logic [15:0] lfsrState;

	fpgaCtrlTop #(
		.VERSION    (VERSION),
		.FLAGS      (FLAGS),
		.BLINK_BITS (BLINK_BITS)
	) i_fpgaCtrlTop (
		.CLK_IN       (CLK_IN),
		.RESET_IN     (RESET_IN),
		.spiSclk      (spiSclk),
		.spiCsN       (spiCsN),
		.spiMosi      (spiMosi),
		.spiMiso      (spiMiso),
		.linkUp       (linkUp),
		.ledOut       (ledOut),
		.linkEnable   (linkEnable),
		.periphKey    (periphKey),
		.periphMask   (periphMask),
		.scrambleIdle (scrambleIdle),
		.gtCfg        (gtCfg)
	);

	fpgaCtrlChecker i_fpgaCtrlChecker (
		.CLK_IN        (CLK_IN),
		.spiSclk       (spiSclk),
		.spiCsN        (spiCsN),
		.spiMiso       (spiMiso),
		.ledOut        (ledOut),
		.linkEnable    (linkEnable),
		.periphKey     (periphKey),
		.periphMask    (periphMask),
		.scrambleIdle  (scrambleIdle),
		.gtCfg         (gtCfg),
		.testName      (testName),
		.readCheck     (readCheck),
		.expRead       (expRead),
		.outCheck      (outCheck),
		.expLinkEnable (modelLinkEn),
		.expKey        (modelKey),
		.expMask       (modelMask),
		.expScramble   (modelScramble),
		.expGtCfg      (modelGt),
		.ledCheck      (ledCheck),
		.ledMode       (ledMode),
		.checkCount    (checkCount),
		.errorCount    (errorCount)
	);

	// 100 MHz clock
	initial
	begin
		CLK_IN = 1'b0;
		forever
			#5 CLK_IN = ~CLK_IN;
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = {lfsrState[14:0],
				lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic modelReset;
		modelKey      = KEY_RESET;
		modelMask     = MASK_RESET;
		modelScramble = SCRM_RESET;
		modelLinkEn   = SLEN_RESET;
		modelLedOvr   = LEDO_RESET;
		modelGt       = '{rxEqMix: RXEQ_RESET, txDiffCtrl: TXDS_RESET, txPreEmphasis: TXPE_RESET};
	endtask

	// Narrow registers keep only their low bits
	task automatic modelWrite(input regAddr_t addr, input regData_t data);
		case (addr)
			PKEY_ADDR: modelKey = data;
			PMSK_ADDR: modelMask = data;
			SCRM_ADDR: modelScramble = data;
			SLEN_ADDR: modelLinkEn = data;
			LEDO_ADDR: modelLedOvr = data[7:0];
			RXEQ_ADDR: modelGt.rxEqMix = data[7:0];
			TXDS_ADDR: modelGt.txDiffCtrl = data[15:0];
			TXPE_ADDR: modelGt.txPreEmphasis = data[11:0];
			// Version, flags and holes in the map stay as they are
			default:
			begin
			end
		endcase
	endtask

	// Expected read value
	function automatic regData_t refRead(input regAddr_t addr);
		case (addr)
			VERS_ADDR: return VERSION;
			FLAG_ADDR: return regData_t'(FLAGS);
			PKEY_ADDR: return modelKey;
			PMSK_ADDR: return modelMask;
			SCRM_ADDR: return modelScramble;
			SLEN_ADDR: return modelLinkEn;
			LEDO_ADDR: return regData_t'(modelLedOvr);
			RXEQ_ADDR: return regData_t'(modelGt.rxEqMix);
			TXDS_ADDR: return regData_t'(modelGt.txDiffCtrl);
			TXPE_ADDR: return regData_t'(modelGt.txPreEmphasis);
			default: return UNMAPPED_DATA;
		endcase
	endfunction

	// Expected LED pattern per LED
	function automatic logic [7:0] expectLeds(input logic [3:0] up, input ledOvr_t ovr);
		logic [7:0] modes;
		for (int i = 0; i < 4; i++)
		begin
			if (up[i] && !ovr[i])
				modes[2*i +: 2] = ovr[4+i] ? LED_DIM : LED_STEADY;
			else
				modes[2*i +: 2] = LED_BLINK;
		end
		return modes;
	endfunction

	// Inputs change 2 ns after the rising edge
	task automatic stepClocks(input int n);
		repeat (n) @(posedge CLK_IN);
		#2;
	endtask

	// Mode 0, MSB first, SCLK at CLK_IN/10
	task automatic spiFrame(input logic [47:0] frame, input int nBits);
		spiCsN = 1'b0;
		stepClocks(5);
		for (int b = 47; b > 47 - nBits; b--)
		begin
			spiMosi = frame[b];
			stepClocks(5);
			spiSclk = 1'b1;
			stepClocks(5);
			spiSclk = 1'b0;
		end
		stepClocks(5);
		spiCsN = 1'b1;
		spiMosi = 1'b0;
		stepClocks(8);
	endtask

	task automatic checkOutputs;
		outCheck = 1'b1;
		stepClocks(1);
		outCheck = 1'b0;
	endtask

	task automatic readReg(input regAddr_t addr);
		expRead = refRead(addr);
		readCheck = 1'b1;
		spiFrame({2'b00, addr, 32'h0}, 48);
		readCheck = 1'b0;
	endtask

	task automatic readAll;
		for (int a = 0; a < 10; a++)
			readReg(regAddr_t'(a));
	endtask

	task automatic writeReg(input regAddr_t addr, input regData_t data);
		spiFrame({2'b10, addr, data}, 48);
		modelWrite(addr, data);
		checkOutputs();
	endtask

	// Counting window of 64 cycles in the checker
	task automatic ledTest(input logic [3:0] up, input ledOvr_t ovr);
		linkUp = up;
		writeReg(LEDO_ADDR, regData_t'(ovr));
		ledMode = expectLeds(up, ovr);
		ledCheck = 1'b1;
		stepClocks(1);
		ledCheck = 1'b0;
		stepClocks(70);
	endtask

	initial
	begin
		regAddr_t addr;
		RESET_IN = 1'b1;
		spiSclk = 1'b0;
		spiCsN = 1'b1;
		spiMosi = 1'b0;
		linkUp = 4'b0000;
		testName = "reset";
		readCheck = 1'b0;
		outCheck = 1'b0;
		ledCheck = 1'b0;
		expRead = '0;
		ledMode = '0;
		lfsrState = 16'd47;
		modelReset();
		repeat (16) @(posedge CLK_IN);
		#2;
		RESET_IN = 1'b0;
		stepClocks(4);

		// Reset values
		checkOutputs();
		readAll();

		// Writable registers, each write read back
		testName = "random";
		for (int n = 0; n < 40; n++)
		begin
			addr = regAddr_t'(2 + randBits(3));
			writeReg(addr, randBits(32));
			readReg(addr);
		end

		// Read-only and unmapped addresses
		testName = "ignored";
		writeReg(VERS_ADDR, randBits(32));
		writeReg(FLAG_ADDR, randBits(32));
		for (int n = 0; n < 4; n++)
		begin
			addr = regAddr_t'(10 + randBits(13));
			writeReg(addr, randBits(32));
			readReg(addr);
		end
		readAll();

		// Chip select rises after 30 bits
		testName = "cut frame";
		spiFrame({2'b10, PKEY_ADDR, randBits(32)}, 30);
		checkOutputs();
		readAll();

		testName = "leds";
		ledTest(4'b1111, 8'h00);
		ledTest(4'b1011, 8'h03);
		ledTest(4'b1111, 8'hF0);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired, the test sequence did not finish in %0d ns", TIMEOUT_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/fpgaCtrl_props.sv
// Assertions on the SPI register port
// Attached by bind to the SPI port inside the top level
`timescale 1ns/1ns
`default_nettype none

module fpgaCtrlProps
(
	input logic       CLK_IN,
	input logic       RESET_IN,
	input logic       spiCsN,
	input logic [5:0] bitCnt,
	input logic       reqValid,
	input logic       spiMiso
);

	// Write request only once all 48 bits are in
	reqAfterFrame: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		reqValid |-> bitCnt == 6'd48)
		else $error("Write request issued before the 48th bit");

	// Single-cycle request pulse
	reqOneCycle: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		reqValid |=> !reqValid)
		else $error("Write request held for more than one cycle");

	// Quiet MISO between frames
	// Chip select passes two sync flops and the state flop before MISO
	misoIdleLow: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		$past(spiCsN, 3) |-> !spiMiso)
		else $error("MISO high while the SPI port is idle");

endmodule

bind spiRegPort fpgaCtrlProps i_fpgaCtrlProps (
	.CLK_IN   (CLK_IN),
	.RESET_IN (RESET_IN),
	.spiCsN   (spiCsN),
	.bitCnt   (bitCnt),
	.reqValid (reqValid),
	.spiMiso  (spiMiso)
);

`default_nettype wire

// File: bench/fpgaCtrlChecker.sv
// Checker for the FPGA control block testbench
// Collects the read word from MISO and compares it at the end of each frame
// Compares the setting outputs and the LED on-counts when the bench asks
// Counts checks and errors for the closing line
`timescale 1ns/1ns
`default_nettype none

module fpgaCtrlChecker
(
	input  logic                  CLK_IN,
	// SPI pins as seen by the board controller
	input  logic                  spiSclk,
	input  logic                  spiCsN,
	input  logic                  spiMiso,
	// DUT outputs
	input  logic [3:0]            ledOut,
	input  fpgaCtrlPkg::regData_t linkEnable,
	input  fpgaCtrlPkg::regData_t periphKey,
	input  fpgaCtrlPkg::regData_t periphMask,
	input  fpgaCtrlPkg::regData_t scrambleIdle,
	input  fpgaCtrlPkg::gtCfg_t   gtCfg,
	// Expected values and strobes from the bench
	input  logic [127:0]          testName,
	input  logic                  readCheck,
	input  fpgaCtrlPkg::regData_t expRead,
	input  logic                  outCheck,
	input  fpgaCtrlPkg::regData_t expLinkEnable,
	input  fpgaCtrlPkg::regData_t expKey,
	input  fpgaCtrlPkg::regData_t expMask,
	input  fpgaCtrlPkg::regData_t expScramble,
	input  fpgaCtrlPkg::gtCfg_t   expGtCfg,
	input  logic                  ledCheck,
	input  logic [7:0]            ledMode,
	output int                    checkCount,
	output int                    errorCount
);
	import fpgaCtrlPkg::*;

	// LED modes, two bits per LED
	localparam logic [1:0] LED_STEADY = 2'd0;
	localparam logic [1:0] LED_BLINK  = 2'd1;
	localparam logic [1:0] LED_DIM    = 2'd2;

	int checks = 0;
	int errors = 0;
	int sclkCount = 0;
	regData_t misoWord;
	logic csLast = 1'b1;
	// LED window
	int ledWindow = 0;
	int onCount [4];

	assign checkCount = checks;
	assign errorCount = errors;

	task automatic compareValue(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error %0s: %0s expected %0h, actual %0h", testName, what,
				expected, actual);
		end
	endtask

	task automatic checkLeds;
		logic [1:0] mode;
		for (int i = 0; i < 4; i++)
		begin
			mode = ledMode[2*i +: 2];
			if (mode == LED_BLINK)
			begin
				checks++;
				// Blinking needs both states inside the window
				if (onCount[i] == 0 || onCount[i] == 64)
				begin
					errors++;
					$display("LED %0d in test %0s did not blink, on for %0d of 64 cycles",
						i, testName, onCount[i]);
				end
			end
			else
				compareValue($sformatf("LED %0d on cycles", i),
					(mode == LED_DIM) ? 64'd8 : 64'd64, 64'(onCount[i]));
		end
	endtask

	// MISO sampled on SCLK rise like the master does
	// SCLK idles low in mode 0, so a low SCLK here means chip select fell
	always @(posedge spiSclk or negedge spiCsN)
	begin
		if (!spiSclk)
			sclkCount = 0;
		else
		begin
			sclkCount = sclkCount + 1;
			// Data phase is bits 17 to 48
			if (sclkCount > 16)
				misoWord = {misoWord[30:0], spiMiso};
		end
	end

	// All comparing on the falling clock edge, away from DUT updates
	always @(negedge CLK_IN)
	begin
		// End of a read frame
		if (!csLast && spiCsN && readCheck)
			compareValue("read data", 64'(expRead), 64'(misoWord));
		csLast = spiCsN;
		if (outCheck)
		begin
			compareValue("linkEnable", 64'(expLinkEnable), 64'(linkEnable));
			compareValue("periphKey", 64'(expKey), 64'(periphKey));
			compareValue("periphMask", 64'(expMask), 64'(periphMask));
			compareValue("scrambleIdle", 64'(expScramble), 64'(scrambleIdle));
			compareValue("gtCfg", 64'(expGtCfg), 64'(gtCfg));
		end
		if (ledCheck)
		begin
			ledWindow = 64;
			for (int i = 0; i < 4; i++)
				onCount[i] = 0;
		end
		else if (ledWindow > 0)
		begin
			for (int i = 0; i < 4; i++)
				if (ledOut[i])
					onCount[i]++;
			ledWindow--;
			if (ledWindow == 0)
				checkLeds();
		end
	end

endmodule

`default_nettype wire

// File: hw/fpgaCtrlTop.sv
// Control and diagnostic block of the serial link board FPGA
// Board controller reaches the register bank over SPI
// Register settings leave as plain outputs for the link logic
// Link state drives the four status LEDs through the override bits
`timescale 1ns/1ns
`default_nettype none

module fpgaCtrlTop #(
	parameter fpgaCtrlPkg::regData_t VERSION = 32'h0000_0000,
	parameter fpgaCtrlPkg::flags_t FLAGS = 6'h00,
	parameter int BLINK_BITS = 4
)
(
	input  logic                  CLK_IN,
	input  logic                  RESET_IN,
	// SPI slave pins
	input  logic                  spiSclk,
	input  logic                  spiCsN,
	input  logic                  spiMosi,
	output logic                  spiMiso,
	// Link state and LEDs, ordered {ring, periph, b2b1, b2b0}
	input  logic [3:0]            linkUp,
	output logic [3:0]            ledOut,
	// Settings for the link logic
	output fpgaCtrlPkg::regData_t linkEnable,
	output fpgaCtrlPkg::regData_t periphKey,
	output fpgaCtrlPkg::regData_t periphMask,
	output fpgaCtrlPkg::regData_t scrambleIdle,
	// Transceiver analog settings
	output fpgaCtrlPkg::gtCfg_t   gtCfg
);
	import fpgaCtrlPkg::*;

	// SPI port to bank
	regReq_t req;
	logic reqValid;
	regData_t readData;
	// Bank to LED driver
	ledOvr_t ledOverride;

	spiRegPort i_spiRegPort (
		.CLK_IN   (CLK_IN),
		.RESET_IN (RESET_IN),
		.spiSclk  (spiSclk),
		.spiCsN   (spiCsN),
		.spiMosi  (spiMosi),
		.spiMiso  (spiMiso),
		.req      (req),
		.reqValid (reqValid),
		.readData (readData)
	);

	regBank #(
		.VERSION (VERSION),
		.FLAGS   (FLAGS)
	) i_regBank (
		.CLK_IN       (CLK_IN),
		.RESET_IN     (RESET_IN),
		.req          (req),
		.reqValid     (reqValid),
		.readData     (readData),
		.linkEnable   (linkEnable),
		.periphKey    (periphKey),
		.periphMask   (periphMask),
		.scrambleIdle (scrambleIdle),
		.ledOverride  (ledOverride),
		.gtCfg        (gtCfg)
	);

	linkStatusLeds #(
		.BLINK_BITS (BLINK_BITS)
	) i_linkStatusLeds (
		.CLK_IN      (CLK_IN),
		.RESET_IN    (RESET_IN),
		.linkUp      (linkUp),
		.ledOverride (ledOverride),
		.ledOut      (ledOut)
	);

endmodule

`default_nettype wire

// File: hw/linkStatusLeds.sv
// Status LED driver for the four serial links
// LED order is {ring, periph, b2b1, b2b0}
// Link up shows steady, link down or forced error blinks
// Dim bits gate the LED down to one cycle in eight
`timescale 1ns/1ns
`default_nettype none

module linkStatusLeds #(
	// Blink period is 2**BLINK_BITS cycles, at least 3 bits for the dim phase
	parameter int BLINK_BITS = 4
)
(
	input  logic                 CLK_IN,
	input  logic                 RESET_IN,
	input  logic [3:0]           linkUp,
	input  fpgaCtrlPkg::ledOvr_t ledOverride,
	output logic [3:0]           ledOut
);

	logic [BLINK_BITS-1:0] phaseCnt;
	logic blinkPhase;
	logic dimPhase;
	logic [3:0] forceErr;
	logic [3:0] dimSel;
	logic [3:0] ledNext;

	// Free-running phase counter
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			phaseCnt <= '0;
		else
			phaseCnt <= phaseCnt + 1'b1;
	end

	// Square wave from the top bit
	assign blinkPhase = phaseCnt[BLINK_BITS-1];
	// High one cycle in eight
	assign dimPhase = (phaseCnt[2:0] == 3'd0);

	assign forceErr = ledOverride[3:0];
	assign dimSel   = ledOverride[7:4];

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			// Healthy link gives a steady LED
			ledNext[i] = (linkUp[i] && !forceErr[i]) ? 1'b1 : blinkPhase;
			if (dimSel[i])
				ledNext[i] = ledNext[i] & dimPhase;
		end
	end

	// Registered so the pins see no glitches
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			ledOut <= 4'b0000;
		else
			ledOut <= ledNext;
	end

endmodule

`default_nettype wire

// File: hw/regBank.sv
// Control and diagnostic register bank
// Single-cycle request interface, a write lands when reqValid is high
// Read data is combinational from the request address
// Register outputs feed the link logic, transceivers and status LEDs
`timescale 1ns/1ns
`default_nettype none

module regBank #(
	// Design version, read-only at VERS_ADDR
	parameter fpgaCtrlPkg::regData_t VERSION = 32'h0000_0000,
	// Compile flags, read-only at FLAG_ADDR
	parameter fpgaCtrlPkg::flags_t FLAGS = 6'h00
)
(
	input  logic                  CLK_IN,
	input  logic                  RESET_IN,
	input  fpgaCtrlPkg::regReq_t  req,
	input  logic                  reqValid,
	output fpgaCtrlPkg::regData_t readData,
	output fpgaCtrlPkg::regData_t linkEnable,
	output fpgaCtrlPkg::regData_t periphKey,
	output fpgaCtrlPkg::regData_t periphMask,
	output fpgaCtrlPkg::regData_t scrambleIdle,
	output fpgaCtrlPkg::ledOvr_t  ledOverride,
	output fpgaCtrlPkg::gtCfg_t   gtCfg
);
	import fpgaCtrlPkg::*;

	logic writeEn;

	// Only write requests reach the bank with reqValid set
	assign writeEn = reqValid && req.write;

	// Write decode
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			periphKey            <= KEY_RESET;
			periphMask           <= MASK_RESET;
			scrambleIdle         <= SCRM_RESET;
			linkEnable           <= SLEN_RESET;
			ledOverride          <= LEDO_RESET;
			gtCfg.rxEqMix        <= RXEQ_RESET;
			gtCfg.txDiffCtrl     <= TXDS_RESET;
			gtCfg.txPreEmphasis  <= TXPE_RESET;
		end
		else if (writeEn)
		begin
			case (req.addr)
				// Multicast route key and mask for the peripheral link
				PKEY_ADDR:
					periphKey <= req.data;
				PMSK_ADDR:
					periphMask <= req.data;
				// Idle scrambling word
				SCRM_ADDR:
					scrambleIdle <= req.data;
				// 2-of-7 link enables
				SLEN_ADDR:
					linkEnable <= req.data;
				// Narrow fields keep only their low bits
				LEDO_ADDR:
					ledOverride <= req.data[7:0];
				// 2 bits per link
				RXEQ_ADDR:
					gtCfg.rxEqMix <= req.data[7:0];
				// 4 bits per link
				TXDS_ADDR:
					gtCfg.txDiffCtrl <= req.data[15:0];
				// 3 bits per link
				TXPE_ADDR:
					gtCfg.txPreEmphasis <= req.data[11:0];
				// Version, flags and unmapped addresses ignore writes
				default:
				begin
				end
			endcase
		end
	end

	// Read mux
	always_comb
	begin
		case (req.addr)
			VERS_ADDR:
				readData = VERSION;
			FLAG_ADDR:
				readData = regData_t'(FLAGS);
			PKEY_ADDR:
				readData = periphKey;
			PMSK_ADDR:
				readData = periphMask;
			SCRM_ADDR:
				readData = scrambleIdle;
			SLEN_ADDR:
				readData = linkEnable;
			// Narrow registers zero-extended
			LEDO_ADDR:
				readData = regData_t'(ledOverride);
			RXEQ_ADDR:
				readData = regData_t'(gtCfg.rxEqMix);
			TXDS_ADDR:
				readData = regData_t'(gtCfg.txDiffCtrl);
			TXPE_ADDR:
				readData = regData_t'(gtCfg.txPreEmphasis);
			default:
				readData = UNMAPPED_DATA;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/spiRegPort.sv
// SPI slave for register access, mode 0, MSB first
// Frame is 48 bits: write flag, spare bit, 14-bit address, 32-bit data
// Pins are oversampled on CLK_IN, so SCLK must stay at or below CLK_IN/8
// Reads shift out the addressed register during the data phase
`timescale 1ns/1ns
`default_nettype none

module spiRegPort
(
	input  logic                  CLK_IN,
	input  logic                  RESET_IN,
	input  logic                  spiSclk,
	input  logic                  spiCsN,
	input  logic                  spiMosi,
	output logic                  spiMiso,
	output fpgaCtrlPkg::regReq_t  req,
	output logic                  reqValid,
	input  fpgaCtrlPkg::regData_t readData
);
	import fpgaCtrlPkg::*;

	// Two-flop synchronizers
	logic [1:0] sclkSync;
	logic [1:0] csSync;
	logic [1:0] mosiSync;
	// Edge flop
	logic sclkLast;
	logic sclkRise;
	logic sclkFall;
	logic csActive;
	logic mosiBit;
	// Frame progress
	spiState_t state;
	logic [5:0] bitCnt;
	logic addrDone;
	logic frameDone;
	logic writeFlag;
	logic loadRead;
	logic misoReg;
	// Payload
	regAddr_t addrReg;
	regData_t dataReg;
	regData_t shiftIn;
	regData_t shiftOut;

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			sclkSync <= 2'b00;
			// Chip select idles high
			csSync   <= 2'b11;
			mosiSync <= 2'b00;
			sclkLast <= 1'b0;
		end
		else
		begin
			sclkSync <= {sclkSync[0], spiSclk};
			csSync   <= {csSync[0], spiCsN};
			mosiSync <= {mosiSync[0], spiMosi};
			sclkLast <= sclkSync[1];
		end
	end

	assign sclkRise = sclkSync[1] & ~sclkLast;
	assign sclkFall = ~sclkSync[1] & sclkLast;
	assign csActive = ~csSync[1];
	assign mosiBit  = mosiSync[1];

	// 16th bit completes flag + spare + address
	assign addrDone  = (state == SPI_ADDR) && sclkRise && (bitCnt == 6'd15);
	// 48th bit completes the frame
	assign frameDone = (state == SPI_DATA) && sclkRise && (bitCnt == 6'd47);

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			state     <= SPI_IDLE;
			bitCnt    <= 6'd0;
			writeFlag <= 1'b0;
			loadRead  <= 1'b0;
			misoReg   <= 1'b0;
			reqValid  <= 1'b0;
		end
		else
		begin
			reqValid <= 1'b0;
			loadRead <= 1'b0;
			if (!csActive)
			begin
				// Chip select high aborts any partial frame
				state   <= SPI_IDLE;
				bitCnt  <= 6'd0;
				misoReg <= 1'b0;
			end
			else
			begin
				case (state)
					SPI_IDLE:
					begin
						state   <= SPI_ADDR;
						bitCnt  <= 6'd0;
						misoReg <= 1'b0;
					end
					SPI_ADDR:
					begin
						if (sclkRise)
							bitCnt <= bitCnt + 6'd1;
						if (addrDone)
						begin
							// First bit of the frame sits 14 places up by now
							writeFlag <= shiftIn[14];
							loadRead  <= 1'b1;
							state     <= SPI_DATA;
						end
					end
					SPI_DATA:
					begin
						if (sclkRise)
							bitCnt <= bitCnt + 6'd1;
						// Master samples on the rising edge, so update on falling
						if (sclkFall)
							misoReg <= shiftOut[31];
						if (frameDone)
						begin
							reqValid <= writeFlag;
							state    <= SPI_FINISH;
						end
					end
					default:
						// Wait here for chip select to rise
						misoReg <= 1'b0;
				endcase
			end
		end
	end

	always_ff @(posedge CLK_IN)
	begin
		if (sclkRise && (state == SPI_ADDR || state == SPI_DATA))
			shiftIn <= {shiftIn[30:0], mosiBit};
		if (addrDone)
			addrReg <= {shiftIn[12:0], mosiBit};
		if (frameDone)
			dataReg <= {shiftIn[30:0], mosiBit};
		// Address register is one cycle old here, so readData is settled
		if (loadRead)
			shiftOut <= readData;
		else if (state == SPI_DATA && sclkFall)
			shiftOut <= {shiftOut[30:0], 1'b0};
	end

	assign req = '{write: writeFlag, addr: addrReg, data: dataReg};
	assign spiMiso = misoReg;

endmodule

`default_nettype wire

// File: hw/fpgaCtrlPkg.sv
// Shared types and constants for the FPGA control register block
// Register map, reset values and the SPI request format live here
// Imported by the SPI port, the register bank and the top level
`default_nettype none

package fpgaCtrlPkg;

	// Register address, 14 bits as carried in an SPI frame
	typedef logic [13:0] regAddr_t;
	// Register data word
	typedef logic [31:0] regData_t;
	// Compile flags
	// {chipscope, periph support, ring support, north/south on front, FPGA ID[1:0]}
	typedef logic [5:0] flags_t;
	// LED overrides
	// Upper nibble dims, lower nibble forces error
	// Each nibble ordered {ring, periph, b2b1, b2b0}
	typedef logic [7:0] ledOvr_t;

	// One register access from the SPI port
	typedef struct packed {
		logic     write;
		regAddr_t addr;
		regData_t data;
	} regReq_t;

	// Transceiver analog settings, one field slice per link
	// Slices ordered {ring, periph, b2b1, b2b0}
	typedef struct packed {
		logic [7:0]  rxEqMix;
		logic [15:0] txDiffCtrl;
		logic [11:0] txPreEmphasis;
	} gtCfg_t;

	// SPI frame phases
	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_ADDR,
		SPI_DATA,
		SPI_FINISH
	} spiState_t;

	// Register map
	localparam regAddr_t VERS_ADDR = 14'd0;
	localparam regAddr_t FLAG_ADDR = 14'd1;
	localparam regAddr_t PKEY_ADDR = 14'd2;
	localparam regAddr_t PMSK_ADDR = 14'd3;
	localparam regAddr_t SCRM_ADDR = 14'd4;
	localparam regAddr_t SLEN_ADDR = 14'd5;
	localparam regAddr_t LEDO_ADDR = 14'd6;
	localparam regAddr_t RXEQ_ADDR = 14'd7;
	localparam regAddr_t TXDS_ADDR = 14'd8;
	localparam regAddr_t TXPE_ADDR = 14'd9;

	// Reset values
	localparam regData_t KEY_RESET  = 32'hFFFF_FFFF;
	localparam regData_t MASK_RESET = 32'h0000_0000;
	localparam regData_t SCRM_RESET = 32'hFFFF_FFFF;
	localparam regData_t SLEN_RESET = 32'h0000_0000;
	// All links show error until software has configured them
	localparam ledOvr_t LEDO_RESET = 8'h0F;
	// B2B links at 5.4 dB, others default
	localparam logic [7:0] RXEQ_RESET = 8'h0A;
	// B2B swing 849 mV, others default
	localparam logic [15:0] TXDS_RESET = 16'h0077;
	// B2B pre-emphasis 1.7 dB
	localparam logic [11:0] TXPE_RESET = 12'h012;

	// Returned for any address outside the map
	localparam regData_t UNMAPPED_DATA = 32'hFFFF_FFFF;

endpackage

`default_nettype wire
